// ==== build.f ====
source/rv_decode_pkg.sv
source/rv_fetch_latch.sv
source/rv_instr_classify.sv
source/rv_imm_gen.sv
source/rv_ctrl_gen.sv
source/rv_decode.sv
verif/rv_decode_props.sv
verif/rv_decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module rv_decode_tb -o rv_decode_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/rv_decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1

// ==== source/rv_ctrl_gen.sv ====
`timescale 1ns/1ps

module rv_ctrl_gen
(
    input  rv_decode_pkg::instr_e    i_instr_kind,
    output logic                     o_reg_write,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_jump,
    output logic                     o_branch,
    output logic                     o_pc_sel,
    output logic                     o_rs1_zero,
    output rv_decode_pkg::res_src_e  o_res_src,
    output rv_decode_pkg::op1_sel_e  o_alu_op1_sel,
    output rv_decode_pkg::op2_sel_e  o_alu_op2_sel,
    output rv_decode_pkg::alu_ctrl_e o_alu_ctrl
);

    import rv_decode_pkg::*;

    logic is_load;
    logic is_store;
    logic is_op_imm;
    logic is_op;
    logic is_jal;
    logic is_jalr;

    assign is_load   = i_instr_kind inside {I_LB, I_LH, I_LW, I_LBU, I_LHU};
    assign is_store  = i_instr_kind inside {I_SB, I_SH, I_SW};
    assign is_op_imm = i_instr_kind inside {I_ADDI, I_SLLI, I_SLTI, I_SLTIU, I_XORI,
                                            I_SRLI, I_SRAI, I_ORI, I_ANDI};
    assign is_op     = i_instr_kind inside {I_ADD, I_SUB, I_SLL, I_SLT, I_SLTU,
                                            I_XOR, I_SRL, I_SRA, I_OR, I_AND};
    assign is_jal    = (i_instr_kind == I_JAL);
    assign is_jalr   = (i_instr_kind == I_JALR);

    assign o_reg_write = is_load | is_op_imm | is_op | is_jal | is_jalr |
                         (i_instr_kind inside {I_AUIPC, I_LUI});
    assign o_mem_read  = is_load;
    assign o_mem_write = is_store;
    assign o_branch    = i_instr_kind inside {I_BEQ, I_BNE, I_BLT, I_BGE, I_BLTU, I_BGEU};
    assign o_jump      = is_jal | is_jalr;
    assign o_pc_sel    = is_jalr;
    // lui adds the immediate to x0
    assign o_rs1_zero  = (i_instr_kind == I_LUI);

    assign o_alu_op1_sel = (is_jal || i_instr_kind == I_AUIPC) ? OP1_PC : OP1_REG;
    assign o_alu_op2_sel = (is_load || is_store || is_op_imm || is_jal || is_jalr ||
                            i_instr_kind inside {I_AUIPC, I_LUI}) ? OP2_IMM : OP2_REG;

    assign o_res_src = is_load ? RES_MEM : ((is_jal || is_jalr) ? RES_PC_P4 : RES_ALU);

    always_comb
    begin
        case (i_instr_kind)
            I_BEQ:                   o_alu_ctrl = ALU_CMP_EQ;
            I_BNE:                   o_alu_ctrl = ALU_CMP_NEQ;
            I_BLT, I_SLT, I_SLTI:    o_alu_ctrl = ALU_CMP_LTS;
            I_BLTU, I_SLTU, I_SLTIU: o_alu_ctrl = ALU_CMP_LTU;
            I_BGE:                   o_alu_ctrl = ALU_CMP_NLTS;
            I_BGEU:                  o_alu_ctrl = ALU_CMP_NLTU;
            I_SUB:                   o_alu_ctrl = ALU_SUB;
            I_XOR, I_XORI:           o_alu_ctrl = ALU_XOR;
            I_OR, I_ORI:             o_alu_ctrl = ALU_OR;
            I_AND, I_ANDI:           o_alu_ctrl = ALU_AND;
            I_SLL, I_SLLI:           o_alu_ctrl = ALU_SHL;
            I_SRL, I_SRLI:           o_alu_ctrl = ALU_SHR;
            I_SRA, I_SRAI:           o_alu_ctrl = ALU_SRA;
            // address and link arithmetic
            default:                 o_alu_ctrl = ALU_ADD;
        endcase
    end

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
(
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_stall,
    input  logic                                i_flush,
    input  rv_decode_pkg::instr_t               i_data,
    input  rv_decode_pkg::pc_t                  i_pc,
    input  rv_decode_pkg::pc_t                  i_pc_p4,
    output rv_decode_pkg::reg_idx_t             o_rs1,
    output rv_decode_pkg::reg_idx_t             o_rs2,
    output rv_decode_pkg::reg_idx_t             o_rd,
    output rv_decode_pkg::pc_t                  o_pc,
    output rv_decode_pkg::pc_t                  o_pc_p4,
    output rv_decode_pkg::instr_t               o_imm,
    output logic [rv_decode_pkg::FUNCT3_W-1:0]  o_funct3,
    output logic                                o_reg_write,
    output logic                                o_mem_read,
    output logic                                o_mem_write,
    output logic                                o_jump,
    output logic                                o_branch,
    output logic                                o_pc_sel,
    output logic                                o_inv_instr,
    output rv_decode_pkg::res_src_e             o_res_src,
    output rv_decode_pkg::op1_sel_e             o_alu_op1_sel,
    output rv_decode_pkg::op2_sel_e             o_alu_op2_sel,
    output rv_decode_pkg::alu_ctrl_e            o_alu_ctrl
);

    import rv_decode_pkg::*;

    instr_t instr;
    instr_e instr_kind;
    logic   supported;
    logic   rs1_zero;

    rv_fetch_latch u_fetch_latch (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_data  (i_data),
        .i_pc    (i_pc),
        .i_pc_p4 (i_pc_p4),
        .o_instr (instr),
        .o_pc    (o_pc),
        .o_pc_p4 (o_pc_p4)
    );

    rv_instr_classify u_classify (
        .i_instr      (instr),
        .o_instr_kind (instr_kind),
        .o_supported  (supported)
    );

    rv_imm_gen u_imm_gen (
        .i_instr      (instr),
        .i_instr_kind (instr_kind),
        .o_imm        (o_imm)
    );

    rv_ctrl_gen u_ctrl_gen (
        .i_instr_kind  (instr_kind),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_rs1_zero    (rs1_zero),
        .o_res_src     (o_res_src),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_alu_ctrl    (o_alu_ctrl)
    );

    // register fields straight from the gated word
    assign o_rs1       = rs1_zero ? '0 : instr[19:15];
    assign o_rs2       = instr[24:20];
    assign o_rd        = instr[11:7];
    assign o_funct3    = instr[14:12];
    assign o_inv_instr = !supported;

endmodule

// ==== source/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int INSTR_W   = 32;
    localparam int REG_IDX_W = 5;
    localparam int FUNCT3_W  = 3;

    // marks SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    // word address, byte offset dropped
    typedef logic [31:2]          pc_t;

    // opcode bits 6..2
    typedef enum logic [4:0] {
        GRP_LOAD     = 5'b00000,
        GRP_MISC_MEM = 5'b00011,
        GRP_OP_IMM   = 5'b00100,
        GRP_AUIPC    = 5'b00101,
        GRP_STORE    = 5'b01000,
        GRP_OP       = 5'b01100,
        GRP_LUI      = 5'b01101,
        GRP_BRANCH   = 5'b11000,
        GRP_JALR     = 5'b11001,
        GRP_JAL      = 5'b11011,
        GRP_SYSTEM   = 5'b11100
    } opgrp_e;

    typedef enum logic [5:0] {
        I_NONE,
        I_LB, I_LH, I_LW, I_LBU, I_LHU,
        I_ADDI, I_SLLI, I_SLTI, I_SLTIU, I_XORI, I_SRLI, I_SRAI, I_ORI, I_ANDI,
        I_AUIPC,
        I_SB, I_SH, I_SW,
        I_ADD, I_SUB, I_SLL, I_SLT, I_SLTU, I_XOR, I_SRL, I_SRA, I_OR, I_AND,
        I_LUI,
        I_BEQ, I_BNE, I_BLT, I_BGE, I_BLTU, I_BGEU,
        I_JALR,
        I_JAL,
        I_FENCE, I_FENCE_I,
        I_ECALL, I_EBREAK,
        I_ILLEGAL
    } instr_e;

    // bit 4 selects arithmetic shift
    typedef enum logic [4:0] {
        ALU_ADD      = 5'b00000,
        ALU_SUB      = 5'b00001,
        ALU_XOR      = 5'b00010,
        ALU_OR       = 5'b00011,
        ALU_AND      = 5'b00100,
        ALU_SHL      = 5'b00101,
        ALU_SHR      = 5'b00110,
        ALU_CMP_EQ   = 5'b01000,
        ALU_CMP_NEQ  = 5'b01001,
        ALU_CMP_LTS  = 5'b01010,
        ALU_CMP_LTU  = 5'b01011,
        ALU_CMP_NLTS = 5'b01100,
        ALU_CMP_NLTU = 5'b01101,
        ALU_SRA      = 5'b10110
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        RES_ALU   = 2'b00,
        RES_MEM   = 2'b01,
        RES_PC_P4 = 2'b10
    } res_src_e;

    typedef enum logic {
        OP1_REG = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_e;

    typedef enum logic {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

endpackage

// ==== source/rv_fetch_latch.sv ====
`timescale 1ns/1ps

module rv_fetch_latch
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  rv_decode_pkg::instr_t i_data,
    input  rv_decode_pkg::pc_t    i_pc,
    input  rv_decode_pkg::pc_t    i_pc_p4,
    output rv_decode_pkg::instr_t o_instr,
    output rv_decode_pkg::pc_t    o_pc,
    output rv_decode_pkg::pc_t    o_pc_p4
);

    logic r_flush;

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_pc    <= '0;
            o_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            o_pc    <= i_pc;
            o_pc_p4 <= i_pc_p4;
        end
    end

    // remembers a flush for one cycle
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            r_flush <= 1'b0;
        else
            r_flush <= i_flush;
    end

    // word fetched behind a flush is dropped
    assign o_instr = (i_reset || r_flush) ? '0 : i_data;

endmodule

// ==== source/rv_imm_gen.sv ====
`timescale 1ns/1ps

module rv_imm_gen
(
    input  rv_decode_pkg::instr_t i_instr,
    input  rv_decode_pkg::instr_e i_instr_kind,
    output rv_decode_pkg::instr_t o_imm
);

    import rv_decode_pkg::*;

    always_comb
    begin
        case (i_instr_kind)
            // J format
            I_JAL:
                o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            // U format
            I_LUI, I_AUIPC:
                o_imm = {i_instr[31:12], 12'b0};
            // I format
            I_JALR,
            I_LB, I_LH, I_LW, I_LBU, I_LHU,
            I_ADDI, I_SLLI, I_SLTI, I_SLTIU, I_XORI, I_SRLI, I_SRAI, I_ORI, I_ANDI:
                o_imm = {{21{i_instr[31]}}, i_instr[30:20]};
            // B format
            I_BEQ, I_BNE, I_BLT, I_BGE, I_BLTU, I_BGEU:
                o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            // S format
            I_SB, I_SH, I_SW:
                o_imm = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
            default:
                o_imm = '0;
        endcase
    end

endmodule

// ==== source/rv_instr_classify.sv ====
`timescale 1ns/1ps

module rv_instr_classify
(
    input  rv_decode_pkg::instr_t i_instr,
    output rv_decode_pkg::instr_e o_instr_kind,
    output logic                  o_supported
);

    import rv_decode_pkg::*;

    opgrp_e      grp;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        f7_zero;
    logic        f7_alt;

    assign grp     = opgrp_e'(i_instr[6:2]);
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign funct12 = i_instr[31:20];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == FUNCT7_ALT);

    always_comb
    begin
        o_instr_kind = I_ILLEGAL;
        if (i_instr == '0)
            o_instr_kind = I_NONE;
        // only 32-bit encodings
        else if (i_instr[1:0] == 2'b11)
        begin
            case (grp)
                GRP_LOAD:
                    case (funct3)
                        3'b000:  o_instr_kind = I_LB;
                        3'b001:  o_instr_kind = I_LH;
                        3'b010:  o_instr_kind = I_LW;
                        3'b100:  o_instr_kind = I_LBU;
                        3'b101:  o_instr_kind = I_LHU;
                        default: o_instr_kind = I_ILLEGAL;
                    endcase
                GRP_OP_IMM:
                    case (funct3)
                        3'b000: o_instr_kind = I_ADDI;
                        3'b001: o_instr_kind = I_SLLI;
                        3'b010: o_instr_kind = I_SLTI;
                        3'b011: o_instr_kind = I_SLTIU;
                        3'b100: o_instr_kind = I_XORI;
                        3'b101: o_instr_kind = f7_zero ? I_SRLI : (f7_alt ? I_SRAI : I_ILLEGAL);
                        3'b110: o_instr_kind = I_ORI;
                        3'b111: o_instr_kind = I_ANDI;
                    endcase
                GRP_OP:
                    case (funct3)
                        3'b000: o_instr_kind = f7_zero ? I_ADD : (f7_alt ? I_SUB : I_ILLEGAL);
                        3'b001: o_instr_kind = f7_zero ? I_SLL : I_ILLEGAL;
                        3'b010: o_instr_kind = f7_zero ? I_SLT : I_ILLEGAL;
                        3'b011: o_instr_kind = f7_zero ? I_SLTU : I_ILLEGAL;
                        3'b100: o_instr_kind = f7_zero ? I_XOR : I_ILLEGAL;
                        3'b101: o_instr_kind = f7_zero ? I_SRL : (f7_alt ? I_SRA : I_ILLEGAL);
                        3'b110: o_instr_kind = f7_zero ? I_OR : I_ILLEGAL;
                        3'b111: o_instr_kind = f7_zero ? I_AND : I_ILLEGAL;
                    endcase
                GRP_STORE:
                    case (funct3)
                        3'b000:  o_instr_kind = I_SB;
                        3'b001:  o_instr_kind = I_SH;
                        3'b010:  o_instr_kind = I_SW;
                        default: o_instr_kind = I_ILLEGAL;
                    endcase
                GRP_BRANCH:
                    case (funct3)
                        3'b000:  o_instr_kind = I_BEQ;
                        3'b001:  o_instr_kind = I_BNE;
                        3'b100:  o_instr_kind = I_BLT;
                        3'b101:  o_instr_kind = I_BGE;
                        3'b110:  o_instr_kind = I_BLTU;
                        3'b111:  o_instr_kind = I_BGEU;
                        default: o_instr_kind = I_ILLEGAL;
                    endcase
                GRP_AUIPC:
                    o_instr_kind = I_AUIPC;
                GRP_LUI:
                    o_instr_kind = I_LUI;
                GRP_JAL:
                    o_instr_kind = I_JAL;
                GRP_JALR:
                    o_instr_kind = (funct3 == 3'b000) ? I_JALR : I_ILLEGAL;
                GRP_MISC_MEM:
                    if (funct3 == 3'b000)
                        o_instr_kind = I_FENCE;
                    else if (funct3 == 3'b001)
                        o_instr_kind = I_FENCE_I;
                GRP_SYSTEM:
                    if (funct3 == 3'b000 && funct12 == 12'h000)
                        o_instr_kind = I_ECALL;
                    else if (funct3 == 3'b000 && funct12 == 12'h001)
                        o_instr_kind = I_EBREAK;
                default:
                    o_instr_kind = I_ILLEGAL;
            endcase
        end
    end

    // ecall and ebreak are recognised but not handled here
    assign o_supported = !(o_instr_kind inside {I_ECALL, I_EBREAK, I_ILLEGAL});

endmodule

// ==== verif/rv_decode_props.sv ====
`timescale 1ns/1ps

module rv_decode_props
(
    input logic i_clk,
    input logic i_reset,
    input logic i_flush,
    input logic i_reg_write,
    input logic i_mem_read,
    input logic i_mem_write,
    input logic i_jump,
    input logic i_pc_sel,
    input logic i_inv_instr
);

    a_mem_excl: assert property (@(posedge i_clk) !(i_mem_read && i_mem_write))
        else $error("memory read and write strobes high together");

    a_pc_sel_jump: assert property (@(posedge i_clk) i_pc_sel |-> i_jump)
        else $error("pc select without jump");

    // word after a flush is a bubble
    a_flush_bubble: assert property (@(posedge i_clk) disable iff (i_reset)
        i_flush |=> !i_reg_write)
        else $error("register write in the cycle after a flush");

    a_reset_valid: assert property (@(posedge i_clk) i_reset |-> !i_inv_instr)
        else $error("invalid instruction flagged during reset");

endmodule

bind rv_decode rv_decode_props u_props (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_flush     (i_flush),
    .i_reg_write (o_reg_write),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write),
    .i_jump      (o_jump),
    .i_pc_sel    (o_pc_sel),
    .i_inv_instr (o_inv_instr)
);

// ==== verif/rv_decode_tb.sv ====
`timescale 1ns/1ps

module rv_decode_tb;

    import rv_decode_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_GEN      = 40;
    localparam int N_REG      = 16;
    localparam logic [6:0] OPC_LOAD = 7'h03;
    localparam logic [6:0] OPC_MISC = 7'h0f;
    localparam logic [6:0] OPC_IMM  = 7'h13;
    localparam logic [6:0] OPC_AUI  = 7'h17;
    localparam logic [6:0] OPC_ST   = 7'h23;
    localparam logic [6:0] OPC_OP   = 7'h33;
    localparam logic [6:0] OPC_LUI  = 7'h37;
    localparam logic [6:0] OPC_JALR = 7'h67;

    // strb is {reg_write, mem_read, mem_write, jump, branch, pc_sel, inv}
    typedef struct packed {
        instr_t    word;
        pc_t       pc;
        instr_t    imm;
        alu_ctrl_e alu;
        res_src_e  res;
        op1_sel_e  op1;
        op2_sel_e  op2;
        logic [6:0] strb;
        reg_idx_t  rs1;
    } row_t;

    logic i_clk, i_reset, i_stall, i_flush;
    instr_t i_data, o_imm;
    pc_t i_pc, i_pc_p4, o_pc, o_pc_p4;
    reg_idx_t o_rs1, o_rs2, o_rd;
    logic [2:0] o_funct3;
    logic o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch, o_pc_sel, o_inv_instr;
    res_src_e o_res_src;
    op1_sel_e o_alu_op1_sel;
    op2_sel_e o_alu_op2_sel;
    alu_ctrl_e o_alu_ctrl;

    row_t rows[$];
    row_t row;
    pc_t pc_seq = 30'h100;
    int seed = 32'h88aec350;
    int n_checks = 0;
    int n_errors = 0;
    int mark_checks = 0;
    int mark_errors = 0;
    logic table_built = 1'b0;
    logic [31:0] r;
    // register group ALU operation by funct3
    alu_ctrl_e op_alu [8] = '{ALU_ADD, ALU_SHL, ALU_CMP_LTS, ALU_CMP_LTU,
                              ALU_XOR, ALU_SHR, ALU_OR, ALU_AND};

    rv_decode dut (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    function automatic instr_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_ST};
    endfunction

    function automatic instr_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic instr_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic row_t make_row(instr_t word, instr_t imm, alu_ctrl_e alu,
                                      res_src_e res, op1_sel_e op1, op2_sel_e op2,
                                      logic [6:0] strb);
        row_t x;
        pc_seq = pc_seq + 30'd3;
        x = '{word, pc_seq, imm, alu, res, op1, op2, strb, word[19:15]};
        return x;
    endfunction

    task automatic tally(input string name, input bit ok, input logic [31:0] got,
                         input logic [31:0] exp);
        n_checks++;
        if (!ok)
        begin
            n_errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input instr_t got, input instr_t exp);
        tally(name, got === exp, got, exp);
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_alu(input string name, input alu_ctrl_e got, input alu_ctrl_e exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_res(input string name, input res_src_e got, input res_src_e exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic end_test(input string name);
        $display("test %-16s checks %0d errors %0d", name,
                 n_checks - mark_checks, n_errors - mark_errors);
        mark_checks = n_checks;
        mark_errors = n_errors;
    endtask

    // pc goes out with the address, the word comes back a cycle later
    task automatic apply_row(input row_t x);
        @(posedge i_clk);
        i_pc    <= x.pc;
        i_pc_p4 <= x.pc + 30'd1;
        i_data  <= '0;
        @(posedge i_clk);
        i_data <= x.word;
        @(negedge i_clk);
        check_pc("o_pc", o_pc, x.pc);
        check_pc("o_pc_p4", o_pc_p4, x.pc + 30'd1);
        check_word("o_imm", o_imm, x.imm);
        check_alu("o_alu_ctrl", o_alu_ctrl, x.alu);
        check_res("o_res_src", o_res_src, x.res);
        check_bit("o_alu_op1_sel", o_alu_op1_sel, x.op1);
        check_bit("o_alu_op2_sel", o_alu_op2_sel, x.op2);
        check_bit("o_reg_write", o_reg_write, x.strb[6]);
        check_bit("o_mem_read", o_mem_read, x.strb[5]);
        check_bit("o_mem_write", o_mem_write, x.strb[4]);
        check_bit("o_jump", o_jump, x.strb[3]);
        check_bit("o_branch", o_branch, x.strb[2]);
        check_bit("o_pc_sel", o_pc_sel, x.strb[1]);
        check_bit("o_inv_instr", o_inv_instr, x.strb[0]);
        check_idx("o_rs1", o_rs1, x.rs1);
    endtask

    task automatic build_table();
        rows.push_back(make_row(enc_i(12'h7f0, 5'd3, 3'b010, 5'd5, OPC_LOAD), 32'h000007f0,
                                ALU_ADD, RES_MEM, OP1_REG, OP2_IMM, 7'b1100000));
        rows.push_back(make_row(enc_i(12'h800, 5'd3, 3'b100, 5'd5, OPC_LOAD), 32'hfffff800,
                                ALU_ADD, RES_MEM, OP1_REG, OP2_IMM, 7'b1100000));
        rows.push_back(make_row(enc_s(12'hffc, 5'd7, 5'd3, 3'b010), 32'hfffffffc,
                                ALU_ADD, RES_ALU, OP1_REG, OP2_IMM, 7'b0010000));
        rows.push_back(make_row(enc_i(12'hffb, 5'd3, 3'b000, 5'd5, OPC_IMM), 32'hfffffffb,
                                ALU_ADD, RES_ALU, OP1_REG, OP2_IMM, 7'b1000000));
        rows.push_back(make_row(enc_i(12'h001, 5'd3, 3'b011, 5'd5, OPC_IMM), 32'h00000001,
                                ALU_CMP_LTU, RES_ALU, OP1_REG, OP2_IMM, 7'b1000000));
        rows.push_back(make_row(enc_i(12'h0f0, 5'd3, 3'b100, 5'd5, OPC_IMM), 32'h000000f0,
                                ALU_XOR, RES_ALU, OP1_REG, OP2_IMM, 7'b1000000));
        rows.push_back(make_row(enc_i(12'h404, 5'd3, 3'b101, 5'd5, OPC_IMM), 32'h00000404,
                                ALU_SRA, RES_ALU, OP1_REG, OP2_IMM, 7'b1000000));
        rows.push_back(make_row(enc_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd5, OPC_OP), 32'h0,
                                ALU_SUB, RES_ALU, OP1_REG, OP2_REG, 7'b1000000));
        rows.push_back(make_row(enc_r(7'h20, 5'd4, 5'd3, 3'b101, 5'd5, OPC_OP), 32'h0,
                                ALU_SRA, RES_ALU, OP1_REG, OP2_REG, 7'b1000000));
        rows.push_back(make_row(enc_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd5, OPC_OP), 32'h0,
                                ALU_CMP_LTS, RES_ALU, OP1_REG, OP2_REG, 7'b1000000));
        row = make_row(enc_u(20'habcde, 5'd5, OPC_LUI), 32'habcde000,
                       ALU_ADD, RES_ALU, OP1_REG, OP2_IMM, 7'b1000000);
        // lui reads x0
        row.rs1 = '0;
        rows.push_back(row);
        rows.push_back(make_row(enc_u(20'h80001, 5'd5, OPC_AUI), 32'h80001000,
                                ALU_ADD, RES_ALU, OP1_PC, OP2_IMM, 7'b1000000));
        rows.push_back(make_row(enc_j(21'h1ffffc, 5'd1), 32'hfffffffc,
                                ALU_ADD, RES_PC_P4, OP1_PC, OP2_IMM, 7'b1001000));
        rows.push_back(make_row(enc_i(12'h010, 5'd3, 3'b000, 5'd1, OPC_JALR), 32'h00000010,
                                ALU_ADD, RES_PC_P4, OP1_REG, OP2_IMM, 7'b1001010));
        rows.push_back(make_row(enc_b(13'h1ff0, 5'd4, 5'd3, 3'b000), 32'hfffffff0,
                                ALU_CMP_EQ, RES_ALU, OP1_REG, OP2_REG, 7'b0000100));
        rows.push_back(make_row(enc_b(13'h0008, 5'd4, 5'd3, 3'b100), 32'h00000008,
                                ALU_CMP_LTS, RES_ALU, OP1_REG, OP2_REG, 7'b0000100));
        rows.push_back(make_row(enc_b(13'h0100, 5'd4, 5'd3, 3'b111), 32'h00000100,
                                ALU_CMP_NLTU, RES_ALU, OP1_REG, OP2_REG, 7'b0000100));
        rows.push_back(make_row(enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC), 32'h0,
                                ALU_ADD, RES_ALU, OP1_REG, OP2_REG, 7'b0000000));
        rows.push_back(make_row(enc_i(12'h000, 5'd0, 3'b001, 5'd0, OPC_MISC), 32'h0,
                                ALU_ADD, RES_ALU, OP1_REG, OP2_REG, 7'b0000000));
        // illegal and unsupported words
        rows.push_back(make_row(32'h00000073, 32'h0, ALU_ADD, RES_ALU, OP1_REG, OP2_REG,
                                7'b0000001));
        rows.push_back(make_row(32'h00100073, 32'h0, ALU_ADD, RES_ALU, OP1_REG, OP2_REG,
                                7'b0000001));
        rows.push_back(make_row(enc_r(7'h01, 5'd4, 5'd3, 3'b000, 5'd5, OPC_OP), 32'h0,
                                ALU_ADD, RES_ALU, OP1_REG, OP2_REG, 7'b0000001));
        rows.push_back(make_row(enc_r(7'h20, 5'd4, 5'd3, 3'b001, 5'd5, OPC_OP), 32'h0,
                                ALU_ADD, RES_ALU, OP1_REG, OP2_REG, 7'b0000001));
        rows.push_back(make_row(32'h0000007f, 32'h0, ALU_ADD, RES_ALU, OP1_REG, OP2_REG,
                                7'b0000001));
        rows.push_back(make_row(32'h00000001, 32'h0, ALU_ADD, RES_ALU, OP1_REG, OP2_REG,
                                7'b0000001));
        rows.push_back(make_row(32'h00000000, 32'h0, ALU_ADD, RES_ALU, OP1_REG, OP2_REG,
                                7'b0000000));
    endtask

    task automatic stall_flush_test();
        instr_t w_add;
        w_add = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP);
        @(posedge i_clk);
        i_pc    <= 30'h2a0;
        i_pc_p4 <= 30'h2a1;
        i_data  <= w_add;
        @(posedge i_clk);
        i_stall <= 1'b1;
        i_pc    <= 30'h2b0;
        i_pc_p4 <= 30'h2b1;
        @(negedge i_clk);
        check_pc("o_pc", o_pc, 30'h2a0);
        @(posedge i_clk);
        i_stall <= 1'b0;
        i_flush <= 1'b1;
        i_pc    <= 30'h2c0;
        i_pc_p4 <= 30'h2c1;
        @(negedge i_clk);
        check_pc("o_pc", o_pc, 30'h2a0);
        check_pc("o_pc_p4", o_pc_p4, 30'h2a1);
        @(posedge i_clk);
        i_flush <= 1'b0;
        i_pc    <= 30'h2d0;
        i_pc_p4 <= 30'h2d1;
        @(negedge i_clk);
        check_pc("o_pc", o_pc, 30'h0);
        check_pc("o_pc_p4", o_pc_p4, 30'h0);
        check_bit("o_reg_write", o_reg_write, 1'b0);
        check_bit("o_inv_instr", o_inv_instr, 1'b0);
        check_idx("o_rd", o_rd, 5'd0);
        @(negedge i_clk);
        check_pc("o_pc", o_pc, 30'h2d0);
        check_bit("o_reg_write", o_reg_write, 1'b1);
        check_idx("o_rd", o_rd, 5'd3);
    endtask

    initial
    begin
        i_reset <= 1'b1;
        i_stall <= 1'b0;
        i_flush <= 1'b0;
        i_data  <= 32'hffffffff;
        i_pc    <= 30'h3ff;
        i_pc_p4 <= 30'h400;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge i_clk);
        // word on the bus is illegal, reset must hide it
        @(negedge i_clk);
        check_pc("o_pc", o_pc, 30'h0);
        check_bit("o_reg_write", o_reg_write, 1'b0);
        check_bit("o_mem_read", o_mem_read, 1'b0);
        check_bit("o_mem_write", o_mem_write, 1'b0);
        check_bit("o_jump", o_jump, 1'b0);
        check_bit("o_branch", o_branch, 1'b0);
        check_bit("o_pc_sel", o_pc_sel, 1'b0);
        check_bit("o_inv_instr", o_inv_instr, 1'b0);
        @(posedge i_clk);
        i_reset <= 1'b0;
        i_data  <= '0;
        @(negedge i_clk);
        check_pc("o_pc", o_pc, 30'h0);
        end_test("reset");

        foreach (rows[i])
            apply_row(rows[i]);
        end_test("table");

        // one immediate format per step, I S B U J in turn
        for (int k = 0; k < N_GEN; k++)
        begin
            r = $random(seed);
            case (k % 5)
                0: row = make_row(enc_i(r[11:0], r[16:12], 3'b000, r[21:17], OPC_IMM),
                                  {{20{r[11]}}, r[11:0]},
                                  ALU_ADD, RES_ALU, OP1_REG, OP2_IMM, 7'b1000000);
                1: row = make_row(enc_s(r[11:0], r[16:12], r[21:17], 3'b010),
                                  {{20{r[11]}}, r[11:0]},
                                  ALU_ADD, RES_ALU, OP1_REG, OP2_IMM, 7'b0010000);
                2: row = make_row(enc_b({r[11:0], 1'b0}, r[16:12], r[21:17], 3'b000),
                                  {{19{r[11]}}, r[11:0], 1'b0},
                                  ALU_CMP_EQ, RES_ALU, OP1_REG, OP2_REG, 7'b0000100);
                3: row = make_row(enc_u(r[19:0], r[24:20], OPC_AUI), {r[19:0], 12'b0},
                                  ALU_ADD, RES_ALU, OP1_PC, OP2_IMM, 7'b1000000);
                default: row = make_row(enc_j({r[19:0], 1'b0}, r[24:20]),
                                        {{11{r[19]}}, r[19:0], 1'b0},
                                        ALU_ADD, RES_PC_P4, OP1_PC, OP2_IMM, 7'b1001000);
            endcase
            apply_row(row);
        end
        end_test("immediates");

        for (int k = 0; k < N_REG; k++)
        begin
            r = $random(seed);
            row = make_row(enc_r(7'h00, r[7:3], r[12:8], r[2:0], r[17:13], OPC_OP), 32'h0,
                           op_alu[r[2:0]], RES_ALU, OP1_REG, OP2_REG, 7'b1000000);
            apply_row(row);
            check_idx("o_rs2", o_rs2, r[7:3]);
            check_idx("o_rd", o_rd, r[17:13]);
            check_idx("o_funct3", {2'b00, o_funct3}, {2'b00, r[2:0]});
        end
        end_test("register fields");

        stall_flush_test();
        end_test("stall and flush");

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // two cycles per row plus margin for reset and the stall sequence
    initial
    begin
        wait (table_built);
        #((rows.size() + N_GEN + N_REG + 20) * 2 * CLK_PERIOD);
        $display("timeout: the tests did not complete in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule
